// File: Bender.yml
package:
  name: dlx_core

export_include_dirs:
  - .

sources:
  - files:
      - dlx_pkg.sv
      - dlx_regfile.sv
      - dlx_fetch.sv
      - dlx_decode.sv
      - dlx_execute.sv
      - dlx_writeback.sv
      - dlx_core.sv
  - target: test
    files:
      - dlx_core_asserts.sv
      - dlx_core_tb.sv

// File: dlx_core.f
+incdir+.
dlx_pkg.sv
dlx_regfile.sv
dlx_fetch.sv
dlx_decode.sv
dlx_execute.sv
dlx_writeback.sv
dlx_core.sv
dlx_core_asserts.sv
dlx_core_tb.sv

// File: dlx_core.sv
// top level of the five-stage DLX integer pipeline
`timescale 1ns/10ps
`include "dlx_defines.svh"

module dlx_core import dlx_pkg::*; (
   input  logic                    clk,
   input  logic                    arst_n,
   // instruction memory
   output logic                    instr_rd_en,
   output logic [`DLX_IADDR_W-1:0] instr_addr,
   input  logic [`DLX_DATA_W-1:0]  instruction,
   // data memory
   output logic                    data_rd_en,
   output logic                    data_wr_en,
   output logic [`DLX_DADDR_W-1:0] data_addr,
   output logic [`DLX_DATA_W-1:0]  data_write,
   input  logic [`DLX_DATA_W-1:0]  data_read,
   // holds fetch at reset pc
   input  logic                    boot_mode
);

   if_id_t    if_id;
   id_ex_t    id_ex;
   ex_mem_t   ex_mem;
   wb_t       wb;
   redirect_t redirect;
   logic      stall;

   // --------------------
   // stages
   // --------------------
   dlx_fetch u_fetch (
      .clk         (clk),
      .arst_n      (arst_n),
      .boot_mode   (boot_mode),
      .stall       (stall),
      .redirect    (redirect),
      .instr_rd_en (instr_rd_en),
      .instr_addr  (instr_addr),
      .instruction (instruction),
      .if_id       (if_id)
   );

   dlx_decode u_decode (
      .clk      (clk),
      .arst_n   (arst_n),
      .if_id    (if_id),
      .redirect (redirect),
      .wb       (wb),
      .stall    (stall),
      .id_ex    (id_ex)
   );

   dlx_execute u_execute (
      .clk      (clk),
      .arst_n   (arst_n),
      .id_ex    (id_ex),
      .wb       (wb),
      .redirect (redirect),
      .ex_mem   (ex_mem)
   );

   dlx_writeback u_writeback (
      .clk       (clk),
      .arst_n    (arst_n),
      .ex_mem    (ex_mem),
      .data_read (data_read),
      .wb        (wb)
   );

   // memory stage is the external data port
   assign data_rd_en = ex_mem.mem_rd;
   assign data_wr_en = ex_mem.mem_wr;
   assign data_addr  = ex_mem.alu;
   assign data_write = ex_mem.store;

endmodule

// File: dlx_core_asserts.sv
// concurrent port checks for the DLX core
`timescale 1ns/10ps
`include "dlx_defines.svh"

module dlx_core_asserts #(
   // stores here come only from squashed instructions
   parameter logic [`DLX_DADDR_W-1:0] MARKER_ADDR = 32'h0000_03F0
) (
   input logic                    clk,
   input logic                    arst_n,
   input logic                    boot_mode,
   input logic                    instr_rd_en,
   input logic [`DLX_IADDR_W-1:0] instr_addr,
   input logic                    data_rd_en,
   input logic                    data_wr_en,
   input logic [`DLX_DADDR_W-1:0] data_addr
);

   // number of failed checks
   int fail_cnt = 0;

   // --------------------
   // fetch side
   // --------------------
   // boot holds fetch at the reset pc
   a_boot_hold: assert property (@(posedge clk) disable iff (!arst_n)
      boot_mode |-> !instr_rd_en && instr_addr == `DLX_RESET_PC)
      else begin
         fail_cnt++;
         $error("fetch active or pc moved during boot");
      end

   a_iaddr_align: assert property (@(posedge clk) disable iff (!arst_n)
      instr_addr[1:0] == 2'b00)
      else begin
         fail_cnt++;
         $error("instruction address not word aligned");
      end

   // --------------------
   // data side
   // --------------------
   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(data_rd_en && data_wr_en))
      else begin
         fail_cnt++;
         $error("data read and write strobes high together");
      end

   // squashed stores never reach memory
   a_no_marker: assert property (@(posedge clk) disable iff (!arst_n)
      data_wr_en |-> data_addr != MARKER_ADDR)
      else begin
         fail_cnt++;
         $error("store to marker address from squashed slot");
      end

   // first cycle out of reset is quiet
   a_reset_quiet: assert property (@(posedge clk)
      $rose(arst_n) |-> !instr_rd_en && !data_rd_en && !data_wr_en)
      else begin
         fail_cnt++;
         $error("strobe high in first cycle after reset");
      end

endmodule

// File: dlx_core_tb.sv
// testbench for the DLX core with memory models, program generator and ISA model
`timescale 1ns/10ps
`include "dlx_defines.svh"

module dlx_core_tb import dlx_pkg::*; ;

   localparam int          STORE_TIMEOUT = 2000;
   // same address as the marker check in the bound assertions
   localparam logic [15:0] MARKER_IMM    = 16'h03F0;

   logic                    clk;
   logic                    arst_n;
   logic                    boot_mode;
   logic                    instr_rd_en;
   logic [`DLX_IADDR_W-1:0] instr_addr;
   logic [`DLX_DATA_W-1:0]  instruction;
   logic                    data_rd_en;
   logic                    data_wr_en;
   logic [`DLX_DADDR_W-1:0] data_addr;
   logic [`DLX_DATA_W-1:0]  data_write;
   logic [`DLX_DATA_W-1:0]  data_read;

   logic [31:0] imem [256];
   logic [31:0] dmem [256];
   logic [7:0]  ird_idx;
   logic [7:0]  drd_idx;
   logic [31:0] lfsr_state;
   int          prog_len;
   int          load_pc;
   int          br_pc;

   // expected stores in program order
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   string       exp_name [$];
   int          exp_total;
   int          store_cnt;
   int          err_cnt;
   int          timeout_cnt;
   int          cycles;

   dlx_core u_dut (.*);

   bind dlx_core dlx_core_asserts u_asserts (.*);

   // --------------------
   // clock
   // --------------------
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // --------------------
   // memory models
   // --------------------
   // word arrives one cycle after the read strobe
   always @(posedge clk) begin
      if (instr_rd_en) begin
         ird_idx = instr_addr[9:2];
         #1;
         instruction = imem[ird_idx];
      end
   end

   always @(posedge clk) begin
      if (data_wr_en) begin
         check_store(data_addr, data_write);
         dmem[data_addr[9:2]] = data_write;
      end
      if (data_rd_en) begin
         drd_idx = data_addr[9:2];
         #1;
         data_read = dmem[drd_idx];
      end
   end

   // pattern over the whole word index
   function automatic logic [31:0] fill_word(input logic [7:0] idx);
      return 32'h5A00_0000 ^ {idx, ~idx, idx, ~idx};
   endfunction

   // --------------------
   // stimulus helpers
   // --------------------
   // galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one lfsr step per bit
   function automatic logic [15:0] rand_imm();
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < 16; i++) begin
         v          = {v[14:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   function automatic logic [31:0] enc_r(input func_e fn, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
      return {OP_SPECIAL, rs1, rs2, rd, 5'd0, fn};
   endfunction

   // rd is the data register for SW
   function automatic logic [31:0] enc_i(input opcode_e op, input logic [4:0] rs1,
                                         input logic [4:0] rd, input logic [15:0] imm);
      return {op, rs1, rd, imm};
   endfunction

   task automatic emit(input logic [31:0] w);
      imem[prog_len] = w;
      prog_len++;
   endtask

   // --------------------
   // program
   // --------------------
   task automatic build_program();
      logic [15:0] offs;
      offs = '0;
      // r20 is the store base
      emit(enc_i(OP_ADDI, 0, 20, 16'h0100));
      for (int it = 0; it < 3; it++) begin
         for (int k = 1; k <= 4; k++) begin
            emit(enc_i(OP_ADDI, 0, k, rand_imm()));
         end
         // back-to-back chain, each op uses the one before
         emit(enc_r(FN_ADD, 5, 1, 2));
         emit(enc_r(FN_SUB, 6, 5, 3));
         emit(enc_r(FN_AND, 7, 6, 5));
         emit(enc_r(FN_OR, 8, 7, 4));
         emit(enc_r(FN_XOR, 9, 8, 6));
         emit(enc_r(FN_SLT, 10, 9, 1));
         emit(enc_i(OP_ADDI, 10, 11, rand_imm()));
         for (int k = 5; k <= 11; k++) begin
            emit(enc_i(OP_SW, 20, k, offs));
            offs = offs + 16'd4;
         end
      end
      load_pc = prog_len * 4;
      // load then use at once, first from fill data
      emit(enc_i(OP_LW, 0, 12, 16'h0200));
      emit(enc_r(FN_ADD, 13, 12, 1));
      emit(enc_i(OP_SW, 20, 13, 16'h0080));
      emit(enc_i(OP_LW, 20, 14, 16'h0000));
      emit(enc_r(FN_ADD, 15, 14, 14));
      emit(enc_i(OP_SW, 20, 15, 16'h0084));
      br_pc = prog_len * 4;
      // taken beqz skips two marker stores
      emit(enc_i(OP_ADDI, 0, 16, 16'h0000));
      emit(enc_i(OP_BEQZ, 16, 0, 16'h0008));
      emit(enc_i(OP_SW, 0, 1, MARKER_IMM));
      emit(enc_i(OP_SW, 0, 2, MARKER_IMM));
      emit({OP_J, 26'h000_0008});
      emit(enc_i(OP_SW, 0, 3, MARKER_IMM));
      emit(enc_i(OP_SW, 0, 4, MARKER_IMM));
      // not taken, both stores must happen
      emit(enc_i(OP_ADDI, 0, 17, 16'h0001));
      emit(enc_i(OP_BEQZ, 17, 0, 16'h0008));
      emit(enc_i(OP_SW, 20, 17, 16'h0088));
      emit(enc_i(OP_SW, 20, 5, 16'h008C));
      // self loop ends the program
      emit({OP_J, 26'h3FF_FFFC});
   endtask

   function automatic string section_name(input int pc);
      if (pc < load_pc) begin
         return "alu_chain";
      end else if (pc < br_pc) begin
         return "load_use";
      end
      return "branch";
   endfunction

   // --------------------
   // ISA reference model
   // --------------------
   task automatic run_model();
      logic [31:0] r [32];
      logic [31:0] m [256];
      logic [19:0] pc;
      logic [19:0] nxt;
      logic [19:0] target;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] ea;
      logic [31:0] res;
      logic [4:0]  dst;
      logic        wr;
      bit          done;
      int          steps;
      foreach (r[i]) r[i] = '0;
      foreach (m[i]) m[i] = fill_word(i);
      pc    = `DLX_RESET_PC;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < 1000) begin
         ins = imem[pc[9:2]];
         // branch and jump offsets count from the next instruction
         nxt = pc + 20'd4;
         a   = r[ins[25:21]];
         b   = r[ins[20:16]];
         imm = {{16{ins[15]}}, ins[15:0]};
         ea  = a + imm;
         dst = ins[20:16];
         res = '0;
         wr  = 1'b0;
         case (ins[31:26])
            OP_SPECIAL: begin
               dst = ins[15:11];
               wr  = 1'b1;
               case (ins[5:0])
                  FN_ADD:  res = a + b;
                  FN_SUB:  res = a - b;
                  FN_AND:  res = a & b;
                  FN_OR:   res = a | b;
                  FN_XOR:  res = a ^ b;
                  FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: wr = 1'b0;
               endcase
            end
            OP_ADDI: begin
               res = ea;
               wr  = 1'b1;
            end
            OP_LW: begin
               res = m[ea[9:2]];
               wr  = 1'b1;
            end
            OP_SW: begin
               m[ea[9:2]] = b;
               exp_addr.push_back(ea);
               exp_data.push_back(b);
               exp_name.push_back(section_name(pc));
            end
            OP_BEQZ: begin
               if (a == '0) begin
                  nxt = nxt + imm[19:0];
               end
            end
            OP_J: begin
               target = nxt + ins[19:0];
               done   = (target == pc);
               nxt    = target;
            end
            default: ;
         endcase
         if (wr && dst != 5'd0) begin
            r[dst] = res;
         end
         pc = nxt;
         steps++;
      end
   endtask

   // --------------------
   // store checking
   // --------------------
   task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
      if (exp_addr.size() == 0) begin
         err_cnt++;
         $display("store not expected by the model, address %h data %h", addr, data);
      end else begin
         assert (addr == exp_addr[0] && data == exp_data[0]) else begin
            err_cnt++;
            $display("error %s: expected [%h] = %h, actual [%h] = %h",
                     exp_name[0], exp_addr[0], exp_data[0], addr, data);
         end
         void'(exp_addr.pop_front());
         void'(exp_data.pop_front());
         void'(exp_name.pop_front());
      end
      store_cnt++;
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      arst_n      = 1'b0;
      boot_mode   = 1'b1;
      instruction = '0;
      data_read   = '0;
      lfsr_state  = 32'h5724;
      prog_len    = 0;
      store_cnt   = 0;
      err_cnt     = 0;
      timeout_cnt = 0;
      foreach (imem[i]) imem[i] = '0;
      foreach (dmem[i]) dmem[i] = fill_word(i);
      build_program();
      run_model();
      exp_total = exp_addr.size();

      repeat (4) @(posedge clk);
      #1 arst_n = 1'b1;
      // boot hold, checked by the bound assertions
      repeat (10) @(posedge clk);
      #1 boot_mode = 1'b0;

      cycles = 0;
      while (store_cnt < exp_total && cycles < STORE_TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (store_cnt < exp_total) begin
         timeout_cnt++;
         $display("timed out with %0d of %0d stores seen", store_cnt, exp_total);
      end
      // let any stray store show up
      repeat (20) @(posedge clk);

      $display("errors: %0d store, %0d assertion, %0d timeout",
               err_cnt, u_dut.u_asserts.fail_cnt, timeout_cnt);
      if (err_cnt == 0 && u_dut.u_asserts.fail_cnt == 0 && timeout_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: dlx_decode.sv
// instruction decode, load-use hazard detection and the ID/EX register
`timescale 1ns/10ps
`include "dlx_defines.svh"

module dlx_decode import dlx_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  if_id_t    if_id,
   input  redirect_t redirect,
   input  wb_t       wb,
   output logic      stall,
   output id_ex_t    id_ex
);

   opcode_e                opcode;
   func_e                  func;
   logic [`DLX_REG_W-1:0]  rs1;
   logic [`DLX_REG_W-1:0]  rs2;
   logic [`DLX_REG_W-1:0]  rd;
   logic [`DLX_DATA_W-1:0] rd1;
   logic [`DLX_DATA_W-1:0] rd2;
   logic [`DLX_DATA_W-1:0] imm_ext;
   ctrl_t                  ctrl;
   alu_op_e                alu_op;
   logic                   imm_sel;
   logic                   use_rs1;
   logic                   use_rs2;
   logic                   load_use;
   logic                   bubble;
   id_ex_t                 id_ex_d;

   // --------------------
   // field split
   // --------------------
   assign opcode  = opcode_e'(if_id.instr[`DLX_OP_LSB +: `DLX_OP_W]);
   assign func    = func_e'(if_id.instr[`DLX_FUNC_W-1:0]);
   assign rs1     = if_id.instr[`DLX_RS1_LSB +: `DLX_REG_W];
   assign rs2     = if_id.instr[`DLX_RS2_LSB +: `DLX_REG_W];
   assign imm_ext = {{(`DLX_DATA_W - `DLX_IMM_W){if_id.instr[`DLX_IMM_W-1]}},
                     if_id.instr[`DLX_IMM_W-1:0]};

   dlx_regfile u_regfile (
      .clk    (clk),
      .arst_n (arst_n),
      .rs1    (rs1),
      .rs2    (rs2),
      .rd1    (rd1),
      .rd2    (rd2),
      .wb     (wb)
   );

   // --------------------
   // control decode
   // --------------------
   always_comb begin
      ctrl    = '0;
      alu_op  = ALU_ADD;
      imm_sel = 1'b0;
      use_rs1 = 1'b1;
      use_rs2 = 1'b0;
      // I-type writes the rs2 field
      rd      = rs2;
      case (opcode)
         OP_SPECIAL: begin
            rd             = if_id.instr[`DLX_RD_LSB +: `DLX_REG_W];
            use_rs2        = 1'b1;
            ctrl.reg_wr_en = 1'b1;
            case (func)
               FN_ADD:  alu_op = ALU_ADD;
               FN_SUB:  alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_SLT:  alu_op = ALU_SLT;
               // unknown function is a nop
               default: ctrl.reg_wr_en = 1'b0;
            endcase
         end
         OP_ADDI: begin
            ctrl.reg_wr_en = 1'b1;
            imm_sel        = 1'b1;
         end
         OP_LW: begin
            ctrl.reg_wr_en = 1'b1;
            ctrl.mem_rd    = 1'b1;
            imm_sel        = 1'b1;
         end
         OP_SW: begin
            // store data comes from the rs2 field
            ctrl.mem_wr = 1'b1;
            imm_sel     = 1'b1;
            use_rs2     = 1'b1;
         end
         OP_BEQZ: begin
            ctrl.is_branch = 1'b1;
         end
         OP_J: begin
            ctrl.is_jump = 1'b1;
            use_rs1      = 1'b0;
         end
         default: begin
            use_rs1 = 1'b0;
         end
      endcase
      // r0 is never written
      if (rd == '0) begin
         ctrl.reg_wr_en = 1'b0;
      end
   end

   // --------------------
   // load-use hazard
   // --------------------
   // load in execute feeds a source here
   assign load_use = if_id.valid & id_ex.valid & id_ex.ctrl.mem_rd & id_ex.ctrl.reg_wr_en &
                     ((use_rs1 & (id_ex.rd == rs1)) | (use_rs2 & (id_ex.rd == rs2)));
   // redirect wins over stall
   assign stall    = load_use & ~redirect.take;
   assign bubble   = ~if_id.valid | load_use | redirect.take;

   always_comb begin
      id_ex_d.valid   = ~bubble;
      id_ex_d.ctrl    = bubble ? '0 : ctrl;
      id_ex_d.alu_op  = alu_op;
      id_ex_d.rs1     = rs1;
      id_ex_d.rs2     = rs2;
      id_ex_d.rd      = rd;
      id_ex_d.op_a    = rd1;
      id_ex_d.op_b    = rd2;
      id_ex_d.imm     = imm_ext;
      id_ex_d.imm_sel = imm_sel;
      id_ex_d.pc      = if_id.pc;
      id_ex_d.offs    = if_id.instr[`DLX_OFFS_W-1:0];
   end

   // ID/EX register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_ex <= '0;
      end else begin
         id_ex <= id_ex_d;
      end
   end

endmodule

// File: dlx_defines.svh
// widths, reset address and instruction field positions of the DLX core
`ifndef DLX_DEFINES_SVH
`define DLX_DEFINES_SVH

// datapath and address widths
`define DLX_DATA_W   32
`define DLX_IADDR_W  20
`define DLX_DADDR_W  32

// instruction field widths
`define DLX_REG_W    5
`define DLX_IMM_W    16
`define DLX_OFFS_W   26
`define DLX_OP_W     6
`define DLX_FUNC_W   6

// lsb of each field in the instruction word
`define DLX_OP_LSB   26
`define DLX_RS1_LSB  21
`define DLX_RS2_LSB  16
`define DLX_RD_LSB   11

// first fetch address
`define DLX_RESET_PC 20'h00000

`endif

// File: dlx_execute.sv
// operand forwarding, ALU, branch and jump resolution and the EX/MEM register
`timescale 1ns/10ps
`include "dlx_defines.svh"

module dlx_execute import dlx_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  id_ex_t    id_ex,
   input  wb_t       wb,
   output redirect_t redirect,
   output ex_mem_t   ex_mem
);

   logic [`DLX_DATA_W-1:0]  op_a;
   logic [`DLX_DATA_W-1:0]  op_b;
   logic [`DLX_DATA_W-1:0]  alu_b;
   logic [`DLX_DATA_W-1:0]  alu_res;
   logic [`DLX_DATA_W-1:0]  offs_ext;
   logic [`DLX_IADDR_W-1:0] br_target;
   logic [`DLX_IADDR_W-1:0] jmp_target;
   logic                    br_taken;
   ex_mem_t                 ex_mem_d;

   // --------------------
   // forwarding
   // --------------------
   // youngest producer first
   function automatic logic [`DLX_DATA_W-1:0] fwd(
      input logic [`DLX_REG_W-1:0]  rs,
      input logic [`DLX_DATA_W-1:0] reg_val
   );
      // a load has no data yet in MEM
      if (ex_mem.valid && ex_mem.reg_wr_en && !ex_mem.mem_rd && ex_mem.rd == rs) begin
         return ex_mem.alu;
      end
      if (wb.wr_en && wb.rd == rs) begin
         return wb.data;
      end
      return reg_val;
   endfunction

   always_comb begin
      op_a = fwd(id_ex.rs1, id_ex.op_a);
      op_b = fwd(id_ex.rs2, id_ex.op_b);
   end

   // --------------------
   // ALU
   // --------------------
   // memory ops use base plus immediate
   assign alu_b = id_ex.imm_sel ? id_ex.imm : op_b;

   always_comb begin
      case (id_ex.alu_op)
         ALU_ADD: alu_res = op_a + alu_b;
         ALU_SUB: alu_res = op_a - alu_b;
         ALU_AND: alu_res = op_a & alu_b;
         ALU_OR:  alu_res = op_a | alu_b;
         ALU_XOR: alu_res = op_a ^ alu_b;
         ALU_SLT: alu_res = {{(`DLX_DATA_W-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
         default: alu_res = op_a + alu_b;
      endcase
   end

   // --------------------
   // branch and jump
   // --------------------
   // pc here already points past the branch
   assign offs_ext   = {{(`DLX_DATA_W - `DLX_OFFS_W){id_ex.offs[`DLX_OFFS_W-1]}}, id_ex.offs};
   assign br_target  = id_ex.pc + id_ex.imm[`DLX_IADDR_W-1:0];
   assign jmp_target = id_ex.pc + offs_ext[`DLX_IADDR_W-1:0];
   // beqz tests the forwarded rs1
   assign br_taken   = id_ex.ctrl.is_branch & (op_a == '0);

   always_comb begin
      redirect.take   = id_ex.valid & (id_ex.ctrl.is_jump | br_taken);
      redirect.target = id_ex.ctrl.is_jump ? jmp_target : br_target;
   end

   // --------------------
   // EX/MEM register
   // --------------------
   always_comb begin
      ex_mem_d.valid     = id_ex.valid;
      ex_mem_d.reg_wr_en = id_ex.valid & id_ex.ctrl.reg_wr_en;
      ex_mem_d.mem_rd    = id_ex.valid & id_ex.ctrl.mem_rd;
      ex_mem_d.mem_wr    = id_ex.valid & id_ex.ctrl.mem_wr;
      ex_mem_d.rd        = id_ex.rd;
      ex_mem_d.alu       = alu_res;
      // store data, forwarded
      ex_mem_d.store     = op_b;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem <= '0;
      end else begin
         ex_mem <= ex_mem_d;
      end
   end

endmodule

// File: dlx_fetch.sv
// program counter with boot hold and redirect, plus the IF/ID register
`timescale 1ns/10ps
`include "dlx_defines.svh"

module dlx_fetch import dlx_pkg::*; (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    boot_mode,
   input  logic                    stall,
   input  redirect_t               redirect,
   output logic                    instr_rd_en,
   output logic [`DLX_IADDR_W-1:0] instr_addr,
   input  logic [`DLX_DATA_W-1:0]  instruction,
   output if_id_t                  if_id
);

   logic [`DLX_IADDR_W-1:0] pc_q;
   // pc+4 of the read in flight
   logic [`DLX_IADDR_W-1:0] rd_pc_q;
   // read issued last cycle, data arrives now
   logic                    rd_q;
   // word that arrived while decode was stalled
   logic                    hold_vld_q;
   logic [`DLX_DATA_W-1:0]  hold_instr_q;

   // --------------------
   // program counter
   // --------------------
   // no read while booting or stalled
   assign instr_rd_en = ~boot_mode & ~stall;
   assign instr_addr  = pc_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc_q <= `DLX_RESET_PC;
         rd_q <= 1'b0;
      end else begin
         if (redirect.take) begin
            pc_q <= redirect.target;
         end else if (instr_rd_en) begin
            pc_q <= pc_q + `DLX_IADDR_W'(4);
         end
         // a read under a redirect is wrong path, drop it
         rd_q <= instr_rd_en & ~redirect.take;
      end
   end

   always_ff @(posedge clk) begin
      if (instr_rd_en) begin
         rd_pc_q <= pc_q + `DLX_IADDR_W'(4);
      end
      // park the word, IF/ID is busy holding
      if (stall && rd_q) begin
         hold_instr_q <= instruction;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hold_vld_q <= 1'b0;
      end else if (redirect.take || !stall) begin
         hold_vld_q <= 1'b0;
      end else begin
         hold_vld_q <= hold_vld_q | rd_q;
      end
   end

   // --------------------
   // IF/ID register
   // --------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         if_id <= '0;
      end else if (redirect.take) begin
         // squash the younger instruction
         if_id.valid <= 1'b0;
      end else if (!stall) begin
         if_id.valid <= rd_q | hold_vld_q;
         if_id.pc    <= rd_pc_q;
         if_id.instr <= hold_vld_q ? hold_instr_q : instruction;
      end
   end

endmodule

// File: dlx_pkg.sv
// enums and stage-to-stage structs shared by the DLX pipeline stages
`include "dlx_defines.svh"

package dlx_pkg;

   // primary opcode, bits 31..26
   typedef enum logic [`DLX_OP_W-1:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_BEQZ    = 6'h04,
      OP_ADDI    = 6'h08,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2B
   } opcode_e;

   // function field of SPECIAL
   typedef enum logic [`DLX_FUNC_W-1:0] {
      FN_ADD = 6'h20,
      FN_SUB = 6'h22,
      FN_AND = 6'h24,
      FN_OR  = 6'h25,
      FN_XOR = 6'h26,
      FN_SLT = 6'h2A
   } func_e;

   // slt is signed, result 1 or 0
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT
   } alu_op_e;

   // --------------------
   // stage structs
   // --------------------
   typedef struct packed {
      logic                    valid;
      // pc of the next instruction
      logic [`DLX_IADDR_W-1:0] pc;
      logic [`DLX_DATA_W-1:0]  instr;
   } if_id_t;

   typedef struct packed {
      logic reg_wr_en;
      logic mem_rd;
      logic mem_wr;
      logic is_branch;
      logic is_jump;
   } ctrl_t;

   typedef struct packed {
      logic                    valid;
      ctrl_t                   ctrl;
      alu_op_e                 alu_op;
      logic [`DLX_REG_W-1:0]   rs1;
      logic [`DLX_REG_W-1:0]   rs2;
      logic [`DLX_REG_W-1:0]   rd;
      logic [`DLX_DATA_W-1:0]  op_a;
      logic [`DLX_DATA_W-1:0]  op_b;
      logic [`DLX_DATA_W-1:0]  imm;
      logic                    imm_sel;
      logic [`DLX_IADDR_W-1:0] pc;
      logic [`DLX_OFFS_W-1:0]  offs;
   } id_ex_t;

   typedef struct packed {
      logic                   valid;
      logic                   reg_wr_en;
      logic                   mem_rd;
      logic                   mem_wr;
      logic [`DLX_REG_W-1:0]  rd;
      logic [`DLX_DATA_W-1:0] alu;
      logic [`DLX_DATA_W-1:0] store;
   } ex_mem_t;

   typedef struct packed {
      logic                   wr_en;
      logic [`DLX_REG_W-1:0]  rd;
      logic [`DLX_DATA_W-1:0] data;
   } wb_t;

   typedef struct packed {
      logic                    take;
      logic [`DLX_IADDR_W-1:0] target;
   } redirect_t;

endpackage

// File: dlx_regfile.sv
// 32-entry register file, r0 reads zero, same-cycle write passes through
`timescale 1ns/10ps
`include "dlx_defines.svh"

module dlx_regfile import dlx_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic [`DLX_REG_W-1:0]  rs1,
   input  logic [`DLX_REG_W-1:0]  rs2,
   output logic [`DLX_DATA_W-1:0] rd1,
   output logic [`DLX_DATA_W-1:0] rd2,
   input  wb_t                    wb
);

   localparam int NUM_REGS = 1 << `DLX_REG_W;

   // r0 has no storage
   logic [`DLX_DATA_W-1:0] regs [1:NUM_REGS-1];

   // registers start at zero
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.wr_en && wb.rd != '0) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // one read port
   function automatic logic [`DLX_DATA_W-1:0] read_port(input logic [`DLX_REG_W-1:0] rs);
      if (rs == '0) begin
         return '0;
      end
      // write-through from write-back
      if (wb.wr_en && wb.rd == rs) begin
         return wb.data;
      end
      return regs[rs];
   endfunction

   always_comb begin
      rd1 = read_port(rs1);
      rd2 = read_port(rs2);
   end

endmodule

// File: dlx_writeback.sv
// MEM/WB register and selection between load data and ALU result
`timescale 1ns/10ps
`include "dlx_defines.svh"

module dlx_writeback import dlx_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   input  ex_mem_t                ex_mem,
   input  logic [`DLX_DATA_W-1:0] data_read,
   output wb_t                    wb
);

   logic                   wr_en_q;
   logic                   load_q;
   logic [`DLX_REG_W-1:0]  rd_q;
   logic [`DLX_DATA_W-1:0] alu_q;

   // MEM/WB control
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_en_q <= 1'b0;
         load_q  <= 1'b0;
      end else begin
         wr_en_q <= ex_mem.valid & ex_mem.reg_wr_en;
         load_q  <= ex_mem.valid & ex_mem.mem_rd;
      end
   end

   // MEM/WB payload
   always_ff @(posedge clk) begin
      rd_q  <= ex_mem.rd;
      alu_q <= ex_mem.alu;
   end

   // load data lands this cycle
   always_comb begin
      wb.wr_en = wr_en_q;
      wb.rd    = rd_q;
      wb.data  = load_q ? data_read : alu_q;
   end

endmodule
